//--- hw/mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [29:0] word_addr_t;
    typedef logic [4:0]  reg_idx_t;

    localparam reg_idx_t reg_zero = 5'd0;

    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_beq   = 6'h04,
        op_addi  = 6'h08,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_e;

    // R-type function field
    typedef enum logic [5:0] {
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_e;

    // Same 32 bits read as an R-type or an I-type word
    typedef union packed {
        struct packed {
            opcode_e    opcode;
            reg_idx_t   rs;
            reg_idx_t   rt;
            reg_idx_t   rd;
            logic [4:0] shamt;
            funct_e     funct;
        } r_fields;
        struct packed {
            opcode_e     opcode;
            reg_idx_t    rs;
            reg_idx_t    rt;
            logic [15:0] imm;
        } i_fields;
    } instr_u;

endpackage

`default_nettype wire

//--- hw/ex_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ex_mem_if;

    logic               reg_write;
    logic               mem_read;
    logic               mem_write;
    mips_pkg::reg_idx_t dest;
    mips_pkg::word_t    alu_result;
    // rt after forwarding, only meaningful for sw
    mips_pkg::word_t    store_data;

    modport producer (
        output reg_write, mem_read, mem_write, dest, alu_result, store_data
    );

    modport consumer (
        input reg_write, mem_read, mem_write, dest, alu_result, store_data
    );

endinterface

`default_nettype wire

//--- hw/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter mips_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             freeze,
    input  logic             stall_id,
    input  logic             branch_taken,
    input  mips_pkg::word_t  branch_target,
    output mips_pkg::word_t  pc,
    output logic             fetch_ren,
    input  mips_pkg::word_t  icache_rdata,
    output mips_pkg::instr_u if_instr,
    output mips_pkg::word_t  if_pc_plus4
);

    mips_pkg::word_t pc_plus4;

    assign pc_plus4 = pc + 32'd4;

    // First request goes out one cycle after reset releases
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_ren <= 1'b0;
        end else begin
            fetch_ren <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (!freeze) begin
            if (branch_taken) begin
                pc <= branch_target;
            end else if (fetch_ren && !stall_id) begin
                pc <= pc_plus4;
            end
        end
    end

    // Taken branch drops the word fetched behind it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_instr <= '0;
        end else if (!freeze) begin
            if (branch_taken || !fetch_ren) begin
                if_instr <= '0;
            end else if (!stall_id) begin
                if_instr <= icache_rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze && !stall_id) begin
            if_pc_plus4 <= pc_plus4;
        end
    end

    // Cache stall holds the fetch address and the pending redirect for the following cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        freeze |=> $stable(pc) && $stable(branch_taken));

endmodule

`default_nettype wire

//--- hw/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic               clk,
    input  logic               rst_n,
    input  mips_pkg::reg_idx_t rs_idx,
    input  mips_pkg::reg_idx_t rt_idx,
    output mips_pkg::word_t    rs_data,
    output mips_pkg::word_t    rt_data,
    input  logic               wb_write,
    input  mips_pkg::reg_idx_t wb_dest,
    input  mips_pkg::word_t    wb_data
);

    mips_pkg::word_t regs [32];

    // Same-cycle writeback value wins over the stored one
    function automatic mips_pkg::word_t read_port(input mips_pkg::reg_idx_t idx);
        if (idx == mips_pkg::reg_zero) begin
            return '0;
        end
        if (wb_write && wb_dest == idx) begin
            return wb_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs_data = read_port(rs_idx);
        rt_data = read_port(rt_idx);
    end

    always_ff @(posedge clk) begin
        if (wb_write) begin
            regs[wb_dest] <= wb_data;
        end
    end

    // Writeback filters register zero before it reaches the array
    assert property (@(posedge clk) disable iff (!rst_n)
        wb_write |-> wb_dest != mips_pkg::reg_zero);

endmodule

`default_nettype wire

//--- hw/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               freeze,
    input  logic               stall_id,
    input  mips_pkg::instr_u   if_instr,
    input  mips_pkg::word_t    if_pc_plus4,
    input  mips_pkg::word_t    rs_data,
    input  mips_pkg::word_t    rt_data,
    input  logic               fwd_mem_rs,
    input  logic               fwd_mem_rt,
    input  mips_pkg::word_t    mem_alu_result,
    output logic               branch_taken,
    output mips_pkg::word_t    branch_target,
    output mips_pkg::alu_op_e  ex_alu_op,
    output logic               ex_alu_src,
    output logic               ex_reg_write,
    output logic               ex_mem_read,
    output logic               ex_mem_write,
    output mips_pkg::reg_idx_t ex_dest,
    output mips_pkg::reg_idx_t ex_rs,
    output mips_pkg::reg_idx_t ex_rt,
    output mips_pkg::word_t    ex_rs_data,
    output mips_pkg::word_t    ex_rt_data,
    output mips_pkg::word_t    ex_imm
);

    mips_pkg::alu_op_e  alu_op;
    logic               alu_src;
    logic               reg_write;
    logic               mem_read;
    logic               mem_write;
    logic               is_beq;
    mips_pkg::reg_idx_t dest;
    mips_pkg::word_t    imm;
    mips_pkg::word_t    cmp_rs;
    mips_pkg::word_t    cmp_rt;

    assign imm = {{16{if_instr.i_fields.imm[15]}}, if_instr.i_fields.imm};

    always_comb begin
        alu_op    = mips_pkg::alu_add;
        alu_src   = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        is_beq    = 1'b0;
        dest      = if_instr.i_fields.rt;
        case (if_instr.r_fields.opcode)
            mips_pkg::op_rtype: begin
                dest      = if_instr.r_fields.rd;
                reg_write = 1'b1;
                case (if_instr.r_fields.funct)
                    mips_pkg::fn_add: alu_op = mips_pkg::alu_add;
                    mips_pkg::fn_sub: alu_op = mips_pkg::alu_sub;
                    mips_pkg::fn_and: alu_op = mips_pkg::alu_and;
                    mips_pkg::fn_or:  alu_op = mips_pkg::alu_or;
                    mips_pkg::fn_slt: alu_op = mips_pkg::alu_slt;
                    // All-zero no-op lands here too
                    default:          reg_write = 1'b0;
                endcase
            end
            mips_pkg::op_addi: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            mips_pkg::op_lw: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
                mem_read  = 1'b1;
            end
            mips_pkg::op_sw: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            mips_pkg::op_beq: is_beq = 1'b1;
            default: ;
        endcase
    end

    // Compare also sees results still sitting in the memory stage
    assign cmp_rs        = fwd_mem_rs ? mem_alu_result : rs_data;
    assign cmp_rt        = fwd_mem_rt ? mem_alu_result : rt_data;
    assign branch_taken  = is_beq && (cmp_rs == cmp_rt) && !stall_id;
    assign branch_target = if_pc_plus4 + {imm[29:0], 2'b00};

    // Stall turns the ID/EX entry into a bubble
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_rs        <= mips_pkg::reg_zero;
            ex_rt        <= mips_pkg::reg_zero;
        end else if (!freeze) begin
            ex_reg_write <= reg_write && !stall_id;
            ex_mem_read  <= mem_read && !stall_id;
            ex_mem_write <= mem_write && !stall_id;
            ex_rs        <= stall_id ? mips_pkg::reg_zero : if_instr.i_fields.rs;
            ex_rt        <= stall_id ? mips_pkg::reg_zero : if_instr.i_fields.rt;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            ex_alu_op  <= alu_op;
            ex_alu_src <= alu_src;
            ex_dest    <= dest;
            ex_rs_data <= rs_data;
            ex_rt_data <= rt_data;
            ex_imm     <= imm;
        end
    end

endmodule

`default_nettype wire

//--- hw/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  mips_pkg::instr_u   id_instr,
    input  logic               ex_mem_read,
    input  logic               ex_reg_write,
    input  mips_pkg::reg_idx_t ex_dest,
    ex_mem_if.consumer         mem,
    input  logic               wb_write,
    input  mips_pkg::reg_idx_t wb_dest,
    input  mips_pkg::reg_idx_t ex_rs,
    input  mips_pkg::reg_idx_t ex_rt,
    output logic               stall_id,
    output logic               fwd_mem_rs,
    output logic               fwd_mem_rt,
    output logic [1:0]         fwd_a,
    output logic [1:0]         fwd_b
);

    mips_pkg::reg_idx_t id_rs;
    mips_pkg::reg_idx_t id_rt;
    logic               is_beq;
    logic               uses_rt;
    logic               mem_alu_write;
    logic               load_use;
    logic               branch_dep;

    // Live write to a nonzero register that matches the source
    function automatic logic hit(input logic wr, input mips_pkg::reg_idx_t dest,
                                 input mips_pkg::reg_idx_t src);
        return wr && dest != mips_pkg::reg_zero && dest == src;
    endfunction

    assign id_rs   = id_instr.i_fields.rs;
    assign id_rt   = id_instr.i_fields.rt;
    assign is_beq  = id_instr.i_fields.opcode == mips_pkg::op_beq;
    // rt is a destination for addi and lw
    assign uses_rt = is_beq || id_instr.r_fields.opcode == mips_pkg::op_rtype
                  || id_instr.r_fields.opcode == mips_pkg::op_sw;

    assign load_use = hit(ex_mem_read, ex_dest, id_rs)
                   || (uses_rt && hit(ex_mem_read, ex_dest, id_rt));

    // Load data in memory is not ready for the compare either
    assign branch_dep = is_beq && (hit(ex_reg_write, ex_dest, id_rs)
                                || hit(ex_reg_write, ex_dest, id_rt)
                                || hit(mem.mem_read, mem.dest, id_rs)
                                || hit(mem.mem_read, mem.dest, id_rt));

    assign stall_id = load_use || branch_dep;

    assign mem_alu_write = mem.reg_write && !mem.mem_read;
    assign fwd_mem_rs    = hit(mem_alu_write, mem.dest, id_rs);
    assign fwd_mem_rt    = hit(mem_alu_write, mem.dest, id_rt);

    // Bit 1 picks the memory stage, bit 0 writeback
    assign fwd_a[1] = hit(mem.reg_write, mem.dest, ex_rs);
    assign fwd_a[0] = !fwd_a[1] && hit(wb_write, wb_dest, ex_rs);
    assign fwd_b[1] = hit(mem.reg_write, mem.dest, ex_rt);
    assign fwd_b[0] = !fwd_b[1] && hit(wb_write, wb_dest, ex_rt);

    // A load always stalls its consumer, so its address never feeds execute
    always_comb begin
        assert (!(mem.mem_read && (fwd_a[1] || fwd_b[1])))
            else $error("load address forwarded from memory stage");
    end

endmodule

`default_nettype wire

//--- hw/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               freeze,
    input  mips_pkg::alu_op_e  ex_alu_op,
    input  logic               ex_alu_src,
    input  logic               ex_reg_write,
    input  logic               ex_mem_read,
    input  logic               ex_mem_write,
    input  mips_pkg::reg_idx_t ex_dest,
    input  mips_pkg::word_t    ex_rs_data,
    input  mips_pkg::word_t    ex_rt_data,
    input  mips_pkg::word_t    ex_imm,
    input  logic [1:0]         fwd_a,
    input  logic [1:0]         fwd_b,
    input  mips_pkg::word_t    wb_data,
    ex_mem_if.producer         mem
);

    mips_pkg::word_t op_a;
    mips_pkg::word_t rt_val;
    mips_pkg::word_t op_b;
    mips_pkg::word_t result;

    assign op_a   = fwd_a[1] ? mem.alu_result : (fwd_a[0] ? wb_data : ex_rs_data);
    assign rt_val = fwd_b[1] ? mem.alu_result : (fwd_b[0] ? wb_data : ex_rt_data);
    assign op_b   = ex_alu_src ? ex_imm : rt_val;

    always_comb begin
        case (ex_alu_op)
            mips_pkg::alu_sub: result = op_a - op_b;
            mips_pkg::alu_and: result = op_a & op_b;
            mips_pkg::alu_or:  result = op_a | op_b;
            mips_pkg::alu_slt: result = {31'd0, $signed(op_a) < $signed(op_b)};
            default:           result = op_a + op_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem.reg_write <= 1'b0;
            mem.mem_read  <= 1'b0;
            mem.mem_write <= 1'b0;
        end else if (!freeze) begin
            mem.reg_write <= ex_reg_write;
            mem.mem_read  <= ex_mem_read;
            mem.mem_write <= ex_mem_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            mem.dest       <= ex_dest;
            mem.alu_result <= result;
            // Store data takes the forwarded rt
            mem.store_data <= rt_val;
        end
    end

endmodule

`default_nettype wire

//--- hw/writeback_unit.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               freeze,
    ex_mem_if.consumer         mem,
    input  mips_pkg::word_t    dcache_rdata,
    output logic               wb_write,
    output mips_pkg::reg_idx_t wb_dest,
    output mips_pkg::word_t    wb_data
);

    logic            wb_load;
    mips_pkg::word_t wb_alu_result;
    mips_pkg::word_t wb_load_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_write <= 1'b0;
            wb_load  <= 1'b0;
        end else if (!freeze) begin
            // Writes to register zero die here
            wb_write <= mem.reg_write && mem.dest != mips_pkg::reg_zero;
            wb_load  <= mem.mem_read;
        end
    end

    // rdata is only sampled once the data cache is ready
    always_ff @(posedge clk) begin
        if (!freeze) begin
            wb_dest       <= mem.dest;
            wb_alu_result <= mem.alu_result;
            wb_load_data  <= dcache_rdata;
        end
    end

    assign wb_data = wb_load ? wb_load_data : wb_alu_result;

endmodule

`default_nettype wire

//--- hw/mips_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module mips_pipeline #(
    parameter mips_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                 clk,
    input  logic                 rst_n,
    output logic                 icache_ren,
    output mips_pkg::word_addr_t icache_addr,
    input  logic                 icache_stall,
    input  mips_pkg::word_t      icache_rdata,
    output logic                 dcache_ren,
    output logic                 dcache_wen,
    output mips_pkg::word_addr_t dcache_addr,
    output mips_pkg::word_t      dcache_wdata,
    input  logic                 dcache_stall,
    input  mips_pkg::word_t      dcache_rdata
);

    logic               freeze;
    logic               stall_id;
    logic               branch_taken;
    mips_pkg::word_t    branch_target;
    mips_pkg::word_t    pc;
    mips_pkg::instr_u   if_instr;
    mips_pkg::word_t    if_pc_plus4;
    mips_pkg::word_t    rs_data;
    mips_pkg::word_t    rt_data;
    logic               fwd_mem_rs;
    logic               fwd_mem_rt;
    logic [1:0]         fwd_a;
    logic [1:0]         fwd_b;
    mips_pkg::alu_op_e  ex_alu_op;
    logic               ex_alu_src;
    logic               ex_reg_write;
    logic               ex_mem_read;
    logic               ex_mem_write;
    mips_pkg::reg_idx_t ex_dest;
    mips_pkg::reg_idx_t ex_rs;
    mips_pkg::reg_idx_t ex_rt;
    mips_pkg::word_t    ex_rs_data;
    mips_pkg::word_t    ex_rt_data;
    mips_pkg::word_t    ex_imm;
    logic               wb_write;
    mips_pkg::reg_idx_t wb_dest;
    mips_pkg::word_t    wb_data;

    ex_mem_if em ();

    // Either cache not ready holds the whole pipeline
    assign freeze = icache_stall | dcache_stall;

    assign icache_addr  = pc[31:2];
    assign dcache_ren   = em.mem_read;
    assign dcache_wen   = em.mem_write;
    assign dcache_addr  = em.alu_result[31:2];
    assign dcache_wdata = em.store_data;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk(clk),
        .rst_n(rst_n),
        .freeze(freeze),
        .stall_id(stall_id),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .pc(pc),
        .fetch_ren(icache_ren),
        .icache_rdata(icache_rdata),
        .if_instr(if_instr),
        .if_pc_plus4(if_pc_plus4)
    );

    register_file u_regs (
        .clk(clk),
        .rst_n(rst_n),
        .rs_idx(if_instr.i_fields.rs),
        .rt_idx(if_instr.i_fields.rt),
        .rs_data(rs_data),
        .rt_data(rt_data),
        .wb_write(wb_write),
        .wb_dest(wb_dest),
        .wb_data(wb_data)
    );

    decode_unit u_decode (
        .clk(clk),
        .rst_n(rst_n),
        .freeze(freeze),
        .stall_id(stall_id),
        .if_instr(if_instr),
        .if_pc_plus4(if_pc_plus4),
        .rs_data(rs_data),
        .rt_data(rt_data),
        .fwd_mem_rs(fwd_mem_rs),
        .fwd_mem_rt(fwd_mem_rt),
        .mem_alu_result(em.alu_result),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .ex_alu_op(ex_alu_op),
        .ex_alu_src(ex_alu_src),
        .ex_reg_write(ex_reg_write),
        .ex_mem_read(ex_mem_read),
        .ex_mem_write(ex_mem_write),
        .ex_dest(ex_dest),
        .ex_rs(ex_rs),
        .ex_rt(ex_rt),
        .ex_rs_data(ex_rs_data),
        .ex_rt_data(ex_rt_data),
        .ex_imm(ex_imm)
    );

    hazard_unit u_hazard (
        .id_instr(if_instr),
        .ex_mem_read(ex_mem_read),
        .ex_reg_write(ex_reg_write),
        .ex_dest(ex_dest),
        .mem(em),
        .wb_write(wb_write),
        .wb_dest(wb_dest),
        .ex_rs(ex_rs),
        .ex_rt(ex_rt),
        .stall_id(stall_id),
        .fwd_mem_rs(fwd_mem_rs),
        .fwd_mem_rt(fwd_mem_rt),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b)
    );

    execute_unit u_execute (
        .clk(clk),
        .rst_n(rst_n),
        .freeze(freeze),
        .ex_alu_op(ex_alu_op),
        .ex_alu_src(ex_alu_src),
        .ex_reg_write(ex_reg_write),
        .ex_mem_read(ex_mem_read),
        .ex_mem_write(ex_mem_write),
        .ex_dest(ex_dest),
        .ex_rs_data(ex_rs_data),
        .ex_rt_data(ex_rt_data),
        .ex_imm(ex_imm),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b),
        .wb_data(wb_data),
        .mem(em)
    );

    writeback_unit u_writeback (
        .clk(clk),
        .rst_n(rst_n),
        .freeze(freeze),
        .mem(em),
        .dcache_rdata(dcache_rdata),
        .wb_write(wb_write),
        .wb_dest(wb_dest),
        .wb_data(wb_data)
    );

endmodule

`default_nettype wire

//--- testbench/tb_mips_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_pipeline;

    localparam mips_pkg::word_t start_pc = 32'h0000_0200;
    localparam int n_stores   = 9;
    localparam int prog_words = 64;
    localparam int wait_limit = 1000;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 icache_ren;
    mips_pkg::word_addr_t icache_addr;
    logic                 icache_stall = 1'b0;
    mips_pkg::word_t      icache_rdata;
    logic                 dcache_ren;
    logic                 dcache_wen;
    mips_pkg::word_addr_t dcache_addr;
    mips_pkg::word_t      dcache_wdata;
    logic                 dcache_stall = 1'b0;
    mips_pkg::word_t      dcache_rdata;

    mips_pkg::instr_u     imem [prog_words];
    mips_pkg::word_addr_t fetch_offset;
    mips_pkg::word_addr_t exp_addr [n_stores];
    mips_pkg::word_t      exp_data [n_stores];
    int                   store_idx;
    logic                 use_stalls;
    string                run_name;

    mips_pipeline #(
        .RESET_PC(start_pc)
    ) UUT (
        .clk(clk),
        .rst_n(rst_n),
        .icache_ren(icache_ren),
        .icache_addr(icache_addr),
        .icache_stall(icache_stall),
        .icache_rdata(icache_rdata),
        .dcache_ren(dcache_ren),
        .dcache_wen(dcache_wen),
        .dcache_addr(dcache_addr),
        .dcache_wdata(dcache_wdata),
        .dcache_stall(dcache_stall),
        .dcache_rdata(dcache_rdata)
    );

    always #10 clk = ~clk;

    // Unloaded data words carry their own address
    function automatic mips_pkg::word_t fill_word(input mips_pkg::word_addr_t addr);
        return {addr, 2'b00} ^ 32'h1234_5678;
    endfunction

    function automatic mips_pkg::instr_u r_instr(input mips_pkg::funct_e fn,
            input mips_pkg::reg_idx_t rd, input mips_pkg::reg_idx_t rs,
            input mips_pkg::reg_idx_t rt);
        mips_pkg::instr_u w;
        w.r_fields.opcode = mips_pkg::op_rtype;
        w.r_fields.rs     = rs;
        w.r_fields.rt     = rt;
        w.r_fields.rd     = rd;
        w.r_fields.shamt  = 5'd0;
        w.r_fields.funct  = fn;
        return w;
    endfunction

    function automatic mips_pkg::instr_u i_instr(input mips_pkg::opcode_e op,
            input mips_pkg::reg_idx_t rt, input mips_pkg::reg_idx_t rs,
            input logic [15:0] imm);
        mips_pkg::instr_u w;
        w.i_fields.opcode = op;
        w.i_fields.rs     = rs;
        w.i_fields.rt     = rt;
        w.i_fields.imm    = imm;
        return w;
    endfunction

    // Cache models answer in the same cycle; fetches outside the program read no-ops
    assign fetch_offset = icache_addr - start_pc[31:2];
    assign icache_rdata = (fetch_offset < 30'(prog_words)) ? imem[fetch_offset[5:0]] : '0;
    assign dcache_rdata = dcache_ren ? fill_word(dcache_addr) : '0;

    task automatic check_addr(input string name, input mips_pkg::word_addr_t expected,
                              input mips_pkg::word_addr_t actual);
        if (actual !== expected) begin
            $display("** Error: %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_data(input string name, input mips_pkg::word_t expected,
                              input mips_pkg::word_t actual);
        if (actual !== expected) begin
            $display("** Error: %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("** Error: %s: expected %0d, actual %0d", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "store count mismatch");
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error: %s: expected %b, actual %b", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "control level mismatch");
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_words; i++) begin
            imem[i] = '0;
        end
        imem[0]  = i_instr(mips_pkg::op_addi, 5'd1, 5'd0, 16'd7);
        imem[1]  = i_instr(mips_pkg::op_addi, 5'd2, 5'd0, 16'hFFFD);
        imem[2]  = r_instr(mips_pkg::fn_add, 5'd3, 5'd1, 5'd2);
        imem[3]  = i_instr(mips_pkg::op_sw, 5'd3, 5'd0, 16'd0);
        imem[4]  = r_instr(mips_pkg::fn_sub, 5'd4, 5'd1, 5'd2);
        imem[5]  = r_instr(mips_pkg::fn_and, 5'd5, 5'd4, 5'd1);
        imem[6]  = r_instr(mips_pkg::fn_or, 5'd6, 5'd5, 5'd4);
        imem[7]  = r_instr(mips_pkg::fn_slt, 5'd7, 5'd2, 5'd1);
        imem[8]  = i_instr(mips_pkg::op_sw, 5'd4, 5'd0, 16'd4);
        imem[9]  = i_instr(mips_pkg::op_sw, 5'd5, 5'd0, 16'd8);
        imem[10] = i_instr(mips_pkg::op_sw, 5'd6, 5'd0, 16'd12);
        imem[11] = i_instr(mips_pkg::op_sw, 5'd7, 5'd0, 16'd16);
        imem[12] = r_instr(mips_pkg::fn_slt, 5'd8, 5'd1, 5'd2);
        imem[13] = i_instr(mips_pkg::op_sw, 5'd8, 5'd0, 16'd20);
        imem[14] = i_instr(mips_pkg::op_addi, 5'd9, 5'd0, 16'h0040);
        imem[15] = i_instr(mips_pkg::op_lw, 5'd10, 5'd9, 16'd0);
        // Load-use pair
        imem[16] = r_instr(mips_pkg::fn_add, 5'd11, 5'd10, 5'd1);
        imem[17] = i_instr(mips_pkg::op_sw, 5'd11, 5'd0, 16'd24);
        imem[18] = i_instr(mips_pkg::op_beq, 5'd1, 5'd1, 16'd1);
        imem[19] = i_instr(mips_pkg::op_sw, 5'd1, 5'd0, 16'd28);
        imem[20] = i_instr(mips_pkg::op_beq, 5'd4, 5'd3, 16'd1);
        imem[21] = i_instr(mips_pkg::op_sw, 5'd3, 5'd0, 16'd32);
        // Branch on a result still in execute
        imem[22] = i_instr(mips_pkg::op_addi, 5'd12, 5'd1, 16'hFFF9);
        imem[23] = i_instr(mips_pkg::op_beq, 5'd0, 5'd12, 16'd1);
        imem[24] = i_instr(mips_pkg::op_sw, 5'd1, 5'd0, 16'd36);
        imem[25] = i_instr(mips_pkg::op_sw, 5'd2, 5'd0, 16'd40);
        imem[26] = i_instr(mips_pkg::op_beq, 5'd0, 5'd0, 16'hFFFF);
    endtask

    // Word address and data of each store in program order
    task automatic load_expected();
        exp_addr = '{30'd0, 30'd1, 30'd2, 30'd3, 30'd4, 30'd5, 30'd6, 30'd8, 30'd10};
        exp_data = '{32'd4, 32'd10, 32'd2, 32'd10, 32'd1, 32'd0,
                     32'h1234_563F, 32'd4, 32'hFFFF_FFFD};
    endtask

    always @(posedge clk) begin
        #1;
        if (use_stalls) begin
            icache_stall = ($urandom % 4) == 0;
            dcache_stall = ($urandom % 3) == 0;
        end else begin
            icache_stall = 1'b0;
            dcache_stall = 1'b0;
        end
    end

    // A store completes at the next edge unless a cache holds the pipeline
    always @(negedge clk) begin
        if (!rst_n) begin
            store_idx = 0;
        end else if (dcache_wen && !icache_stall && !dcache_stall) begin
            if (store_idx >= n_stores) begin
                check_count({run_name, " store count"}, n_stores, store_idx + 1);
            end else begin
                check_addr($sformatf("%s store %0d address", run_name, store_idx),
                           exp_addr[store_idx], dcache_addr);
                check_data($sformatf("%s store %0d data", run_name, store_idx),
                           exp_data[store_idx], dcache_wdata);
                store_idx = store_idx + 1;
            end
        end
    end

    task automatic run_program(input string name, input logic stalls);
        int cycles;
        @(posedge clk);
        #1;
        rst_n      = 1'b0;
        run_name   = name;
        @(posedge clk);
        @(negedge clk);
        use_stalls = stalls;
        check_level({name, " dcache_ren during reset"}, 1'b0, dcache_ren);
        check_level({name, " dcache_wen during reset"}, 1'b0, dcache_wen);
        check_level({name, " icache_ren during reset"}, 1'b0, icache_ren);
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        cycles = 0;
        while (!icache_ren) begin
            @(negedge clk);
            cycles++;
            if (cycles > wait_limit) begin
                $display("Simulation failed");
                $fatal(1, "instruction fetch never started after reset");
            end
        end
        check_addr({name, " first fetch address"}, start_pc[31:2], icache_addr);
        cycles = 0;
        while (store_idx < n_stores) begin
            @(posedge clk);
            cycles++;
            if (cycles > wait_limit) begin
                $display("Simulation failed");
                $fatal(1, "the program did not finish its stores in time");
            end
        end
        // Program now spins on its last branch, so no store may follow
        repeat (30) @(posedge clk);
    endtask

    initial begin
        void'($urandom(28));
        rst_n      = 1'b0;
        use_stalls = 1'b0;
        run_name   = "";
        load_program();
        load_expected();
        run_program("no stalls", 1'b0);
        run_program("random stalls", 1'b1);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
hw/mips_pkg.sv
hw/ex_mem_if.sv
hw/fetch_unit.sv
hw/register_file.sv
hw/decode_unit.sv
hw/hazard_unit.sv
hw/execute_unit.sv
hw/writeback_unit.sv
hw/mips_pipeline.sv
testbench/tb_mips_pipeline.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run, the exit status carries the verdict
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_mips_pipeline -f files.f \
    && ./obj_dir/Vtb_mips_pipeline \
    || exit 1
